// ==== source/rvCorePkg.sv ====
package rvCorePkg;

	// base opcodes, instr[6:0]
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASSB
	} aluOp_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_PC4
	} wbSel_t;

	typedef struct packed {
		aluOp_t      aluOp;
		logic        aSelPc;
		logic        bSelImm;
		logic        regWrite;
		wbSel_t      wbSel;
		logic        isBranch;
		logic        isJal;
		logic        isJalr;
		logic        isLoad;
		logic        isStore;
		// access size/sign or branch condition
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] addr;
		// already placed in its byte lanes
		logic [31:0] wdata;
		logic [3:0]  byteEn;
		logic        read;
		logic        write;
	} memReq_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic        regWrite;
		logic [31:0] wdata;
	} retire_t;

endpackage

// ==== source/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode (
	input  logic [31:0]       instr_i,
	output rvCorePkg::ctrl_t  ctrl_o,
	output logic [31:0]       imm_o
);
	import rvCorePkg::*;

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic        funct7b5;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immU;
	logic [31:0] immJ;

	function automatic aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
		aluOp_t op;
		case (f3)
			3'b000: op = alt ? ALU_SUB : ALU_ADD;
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: op = alt ? ALU_SRA : ALU_SRL;
			3'b110: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode   = instr_i[6:0];
	assign funct3   = instr_i[14:12];
	assign funct7b5 = instr_i[30];

	assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
	assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign immU = {instr_i[31:12], 12'b0};
	assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb begin
		// unknown opcodes fall through as a no-op
		ctrl_o          = '0;
		ctrl_o.aluOp    = ALU_ADD;
		ctrl_o.wbSel    = WB_ALU;
		ctrl_o.funct3   = funct3;
		ctrl_o.rd       = instr_i[11:7];
		ctrl_o.rs1      = instr_i[19:15];
		ctrl_o.rs2      = instr_i[24:20];
		imm_o           = 32'b0;

		case (opcode)
			OP_LUI: begin
				ctrl_o.aluOp    = ALU_PASSB;
				ctrl_o.bSelImm  = 1'b1;
				ctrl_o.regWrite = 1'b1;
				imm_o           = immU;
			end
			OP_AUIPC: begin
				ctrl_o.aSelPc   = 1'b1;
				ctrl_o.bSelImm  = 1'b1;
				ctrl_o.regWrite = 1'b1;
				imm_o           = immU;
			end
			OP_JAL: begin
				ctrl_o.aSelPc   = 1'b1;
				ctrl_o.bSelImm  = 1'b1;
				ctrl_o.regWrite = 1'b1;
				ctrl_o.wbSel    = WB_PC4;
				ctrl_o.isJal    = 1'b1;
				imm_o           = immJ;
			end
			OP_JALR: begin
				ctrl_o.bSelImm  = 1'b1;
				ctrl_o.regWrite = 1'b1;
				ctrl_o.wbSel    = WB_PC4;
				ctrl_o.isJalr   = 1'b1;
				imm_o           = immI;
			end
			OP_BRANCH: begin
				// alu forms the target, compare is separate
				ctrl_o.aSelPc   = 1'b1;
				ctrl_o.bSelImm  = 1'b1;
				ctrl_o.isBranch = 1'b1;
				imm_o           = immB;
			end
			OP_LOAD: begin
				ctrl_o.bSelImm  = 1'b1;
				ctrl_o.regWrite = 1'b1;
				ctrl_o.wbSel    = WB_LOAD;
				ctrl_o.isLoad   = 1'b1;
				imm_o           = immI;
			end
			OP_STORE: begin
				ctrl_o.bSelImm  = 1'b1;
				ctrl_o.isStore  = 1'b1;
				imm_o           = immS;
			end
			OP_IMM: begin
				// funct7 bit 5 only matters for srai
				ctrl_o.aluOp    = aluFromFunct(funct3, (funct3 == 3'b101) & funct7b5);
				ctrl_o.bSelImm  = 1'b1;
				ctrl_o.regWrite = 1'b1;
				imm_o           = immI;
			end
			OP_REG: begin
				ctrl_o.aluOp    = aluFromFunct(funct3, funct7b5);
				ctrl_o.regWrite = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic        clk_mem,
	input  logic        rst,
	input  logic [4:0]  rs1_i,
	input  logic [4:0]  rs2_i,
	input  logic [4:0]  rd_i,
	input  logic        we_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata1_o,
	output logic [31:0] rdata2_o
);

	// x0 has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'b0;
			end
		end else if (we_i && (rd_i != 5'd0)) begin
			regs[rd_i] <= wdata_i;
		end
	end

	assign rdata1_o = (rs1_i == 5'd0) ? 32'b0 : regs[rs1_i];
	assign rdata2_o = (rs2_i == 5'd0) ? 32'b0 : regs[rs2_i];

endmodule

// ==== source/execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
	input  logic [31:0]         pc_i,
	input  logic [31:0]         imm_i,
	input  logic [31:0]         rs1Val_i,
	input  logic [31:0]         rs2Val_i,
	input  rvCorePkg::ctrl_t    ctrl_i,
	output logic [31:0]         aluResult_o,
	output logic [31:0]         nextPc_o,
	output rvCorePkg::memReq_t  memReq_o
);
	import rvCorePkg::*;

	logic [31:0] opA;
	logic [31:0] opB;
	logic [4:0]  shamt;
	logic        isEq;
	logic        isLt;
	logic        isLtu;
	logic        taken;
	logic [31:0] pcPlus4;

	assign opA   = ctrl_i.aSelPc ? pc_i : rs1Val_i;
	assign opB   = ctrl_i.bSelImm ? imm_i : rs2Val_i;
	assign shamt = opB[4:0];

	always_comb begin
		case (ctrl_i.aluOp)
			ALU_ADD:  aluResult_o = opA + opB;
			ALU_SUB:  aluResult_o = opA - opB;
			ALU_SLL:  aluResult_o = opA << shamt;
			ALU_SLT:  aluResult_o = {31'b0, $signed(opA) < $signed(opB)};
			ALU_SLTU: aluResult_o = {31'b0, opA < opB};
			ALU_XOR:  aluResult_o = opA ^ opB;
			ALU_SRL:  aluResult_o = opA >> shamt;
			ALU_SRA:  aluResult_o = $unsigned($signed(opA) >>> shamt);
			ALU_OR:   aluResult_o = opA | opB;
			ALU_AND:  aluResult_o = opA & opB;
			default:  aluResult_o = opB;
		endcase
	end

	// branch compare always on the register operands
	assign isEq  = (rs1Val_i == rs2Val_i);
	assign isLt  = ($signed(rs1Val_i) < $signed(rs2Val_i));
	assign isLtu = (rs1Val_i < rs2Val_i);

	always_comb begin
		case (ctrl_i.funct3)
			3'b000:  taken = isEq;
			3'b001:  taken = ~isEq;
			3'b100:  taken = isLt;
			3'b101:  taken = ~isLt;
			3'b110:  taken = isLtu;
			3'b111:  taken = ~isLtu;
			default: taken = 1'b0;
		endcase
	end

	assign pcPlus4 = pc_i + 32'd4;

	always_comb begin
		if (ctrl_i.isJal | ctrl_i.isJalr) begin
			nextPc_o = {aluResult_o[31:1], 1'b0};
		end else if (ctrl_i.isBranch & taken) begin
			nextPc_o = aluResult_o;
		end else begin
			nextPc_o = pcPlus4;
		end
	end

	always_comb begin
		memReq_o.addr  = aluResult_o;
		memReq_o.wdata = rs2Val_i << {aluResult_o[1:0], 3'b000};
		case (ctrl_i.funct3[1:0])
			2'b00:   memReq_o.byteEn = 4'b0001 << aluResult_o[1:0];
			2'b01:   memReq_o.byteEn = 4'b0011 << aluResult_o[1:0];
			default: memReq_o.byteEn = 4'b1111;
		endcase
		memReq_o.read  = ctrl_i.isLoad;
		memReq_o.write = ctrl_i.isStore;
	end

endmodule

// ==== source/resultSelect.sv ====
`timescale 1ns/1ps

module resultSelect (
	input  rvCorePkg::ctrl_t  ctrl_i,
	input  logic [31:0]       aluResult_i,
	input  logic [31:0]       loadWord_i,
	input  logic [31:0]       pcPlus4_i,
	input  logic [1:0]        addrLow_i,
	output logic [31:0]       wbData_o
);
	import rvCorePkg::*;

	logic [31:0] shifted;
	logic [31:0] loadVal;

	// bring the addressed lane down to bit 0
	assign shifted = loadWord_i >> {addrLow_i, 3'b000};

	always_comb begin
		case (ctrl_i.funct3)
			3'b000:  loadVal = {{24{shifted[7]}}, shifted[7:0]};
			3'b001:  loadVal = {{16{shifted[15]}}, shifted[15:0]};
			3'b100:  loadVal = {24'b0, shifted[7:0]};
			3'b101:  loadVal = {16'b0, shifted[15:0]};
			default: loadVal = shifted;
		endcase
	end

	always_comb begin
		case (ctrl_i.wbSel)
			WB_LOAD: wbData_o = loadVal;
			WB_PC4:  wbData_o = pcPlus4_i;
			default: wbData_o = aluResult_i;
		endcase
	end

endmodule

// ==== source/coreSequencer.sv ====
`timescale 1ns/1ps

module coreSequencer #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic                clk_mem,
	input  logic                rst,
	input  logic                imemReady_i,
	input  logic [31:0]         imemData_i,
	input  logic                dmemReady_i,
	input  rvCorePkg::ctrl_t    ctrl_i,
	input  logic [31:0]         nextPc_i,
	input  logic [31:0]         wbData_i,
	input  rvCorePkg::memReq_t  memReqComb_i,
	output logic                imemRead_o,
	output logic [31:0]         pc_o,
	output logic [31:0]         instr_o,
	output rvCorePkg::memReq_t  dmemReq_o,
	output logic                regWe_o,
	output rvCorePkg::retire_t  retire_o
);

	typedef enum logic {
		FETCH,
		EXEC
	} state_t;

	state_t      state;
	logic        running;
	logic [31:0] pc;
	logic [31:0] instrQ;
	logic        memOp;
	logic        fetchDone;
	logic        execDone;

	assign memOp     = ctrl_i.isLoad | ctrl_i.isStore;
	assign fetchDone = imemRead_o & imemReady_i;
	// memory ops wait for the data port
	assign execDone  = (state == EXEC) & (~memOp | dmemReady_i);

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			state   <= FETCH;
			running <= 1'b0;
			pc      <= RESET_PC;
		end else begin
			running <= 1'b1;
			case (state)
				FETCH: begin
					if (fetchDone) begin
						state <= EXEC;
					end
				end
				default: begin
					if (execDone) begin
						state <= FETCH;
						pc    <= nextPc_i;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_mem) begin
		if (fetchDone) begin
			instrQ <= imemData_i;
		end
	end

	// first fetch waits one cycle past reset
	assign imemRead_o = running & (state == FETCH);
	assign pc_o       = pc;
	assign instr_o    = instrQ;

	always_comb begin
		dmemReq_o       = memReqComb_i;
		dmemReq_o.read  = memReqComb_i.read & (state == EXEC);
		dmemReq_o.write = memReqComb_i.write & (state == EXEC);
	end

	assign regWe_o = execDone & ctrl_i.regWrite;

	always_comb begin
		retire_o.valid    = execDone;
		retire_o.pc       = pc;
		retire_o.rd       = ctrl_i.rd;
		retire_o.regWrite = ctrl_i.regWrite;
		retire_o.wdata    = wbData_i;
	end

endmodule

// ==== source/rvCore.sv ====
`timescale 1ns/1ps

module rvCore #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic                clk_mem,
	input  logic                rst,
	output logic [31:0]         imemAddr_o,
	output logic                imemRead_o,
	input  logic [31:0]         imemData_i,
	input  logic                imemReady_i,
	output rvCorePkg::memReq_t  dmemReq_o,
	input  logic [31:0]         dmemRdata_i,
	input  logic                dmemReady_i,
	output rvCorePkg::retire_t  retire_o
);
	import rvCorePkg::*;

	ctrl_t       ctrl;
	memReq_t     memReqComb;
	logic [31:0] pc;
	logic [31:0] instr;
	logic [31:0] imm;
	logic [31:0] rs1Val;
	logic [31:0] rs2Val;
	logic [31:0] aluResult;
	logic [31:0] nextPc;
	logic [31:0] wbData;
	logic        regWe;
	wire  [31:0] pcPlus4 = pc + 32'd4;

	assign imemAddr_o = pc;

	coreSequencer #(
		.RESET_PC     (RESET_PC)
	) uSeq (
		.clk_mem      (clk_mem),
		.rst          (rst),
		.imemReady_i  (imemReady_i),
		.imemData_i   (imemData_i),
		.dmemReady_i  (dmemReady_i),
		.ctrl_i       (ctrl),
		.nextPc_i     (nextPc),
		.wbData_i     (wbData),
		.memReqComb_i (memReqComb),
		.imemRead_o   (imemRead_o),
		.pc_o         (pc),
		.instr_o      (instr),
		.dmemReq_o    (dmemReq_o),
		.regWe_o      (regWe),
		.retire_o     (retire_o)
	);

	instrDecode uDecode (
		.instr_i      (instr),
		.ctrl_o       (ctrl),
		.imm_o        (imm)
	);

	regFile uRegs (
		.clk_mem      (clk_mem),
		.rst          (rst),
		.rs1_i        (ctrl.rs1),
		.rs2_i        (ctrl.rs2),
		.rd_i         (ctrl.rd),
		.we_i         (regWe),
		.wdata_i      (wbData),
		.rdata1_o     (rs1Val),
		.rdata2_o     (rs2Val)
	);

	execUnit uExec (
		.pc_i         (pc),
		.imm_i        (imm),
		.rs1Val_i     (rs1Val),
		.rs2Val_i     (rs2Val),
		.ctrl_i       (ctrl),
		.aluResult_o  (aluResult),
		.nextPc_o     (nextPc),
		.memReq_o     (memReqComb)
	);

	resultSelect uResult (
		.ctrl_i       (ctrl),
		.aluResult_i  (aluResult),
		.loadWord_i   (dmemRdata_i),
		.pcPlus4_i    (pcPlus4),
		.addrLow_i    (memReqComb.addr[1:0]),
		.wbData_o     (wbData)
	);

endmodule

// ==== sim/rvCore_props.sv ====
`timescale 1ns/1ps

module rvCoreProps (
	input logic                clk_mem,
	input logic                rst,
	input logic                imemRead_i,
	input logic [31:0]         imemAddr_i,
	input logic                imemReady_i,
	input rvCorePkg::memReq_t  dmemReq_i,
	input logic                dmemReady_i,
	input rvCorePkg::retire_t  retire_i
);

	// quiet once reset has been seen on an edge
	resetQuiet: assert property (@(posedge clk_mem)
		(rst ##1 rst) |-> (!imemRead_i && !dmemReq_i.read && !dmemReq_i.write && !retire_i.valid))
		else $error("request or retire active during reset");

	imemHold: assert property (@(posedge clk_mem) disable iff (rst)
		(imemRead_i && !imemReady_i) |=> (imemRead_i && $stable(imemAddr_i)))
		else $error("instruction request changed before ready");

	readHold: assert property (@(posedge clk_mem) disable iff (rst)
		(dmemReq_i.read && !dmemReady_i) |=> (dmemReq_i.read && $stable(dmemReq_i)))
		else $error("data read changed before ready");

	writeHold: assert property (@(posedge clk_mem) disable iff (rst)
		(dmemReq_i.write && !dmemReady_i) |=> (dmemReq_i.write && $stable(dmemReq_i)))
		else $error("data write changed before ready");

	retireSingle: assert property (@(posedge clk_mem) disable iff (rst)
		retire_i.valid |=> !retire_i.valid)
		else $error("retire valid high two cycles in a row");

endmodule

bind rvCore rvCoreProps uProps (
	.clk_mem     (clk_mem),
	.rst         (rst),
	.imemRead_i  (imemRead_o),
	.imemAddr_i  (imemAddr_o),
	.imemReady_i (imemReady_i),
	.dmemReq_i   (dmemReq_o),
	.dmemReady_i (dmemReady_i),
	.retire_i    (retire_o)
);

// ==== sim/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb;
	import rvCorePkg::*;

	localparam logic [31:0] RESET_PC  = 32'h0000_0040;
	localparam logic [31:0] DATA_BASE = 32'h0000_1000;
	localparam int          MEM_WORDS = 2048;
	localparam int          TIMEOUT   = 5000;

	logic        clk_mem;
	logic        rst;
	logic [31:0] imemAddr;
	logic        imemRead;
	logic [31:0] imemData;
	logic        imemReady;
	memReq_t     dmemReq;
	logic [31:0] dmemRdata;
	logic        dmemReady;
	retire_t     retire;

	// DUT memory and the reference copy
	logic [31:0] mem [MEM_WORDS];
	logic [31:0] refMem [MEM_WORDS];
	logic [31:0] refRegs [32];
	logic [31:0] refPc;
	logic [31:0] prog [$];

	integer seed = 32'hd26cc40e;
	int     errors = 0;
	int     testsRun = 0;
	int     testsFailed = 0;
	int     retireCount = 0;
	int     fetchCount = 0;
	int     iDelay = 0;
	int     dDelay = 0;
	bit     iBusy = 1'b0;
	bit     dBusy = 1'b0;
	bit     randLat = 1'b0;
	logic   rstQ;

	rvCore #(
		.RESET_PC    (RESET_PC)
	) dut_i (
		.clk_mem     (clk_mem),
		.rst         (rst),
		.imemAddr_o  (imemAddr),
		.imemRead_o  (imemRead),
		.imemData_i  (imemData),
		.imemReady_i (imemReady),
		.dmemReq_o   (dmemReq),
		.dmemRdata_i (dmemRdata),
		.dmemReady_i (dmemReady),
		.retire_o    (retire)
	);

	initial begin
		clk_mem = 1'b0;
		forever #2 clk_mem = ~clk_mem;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %08h expected %08h", name, got, exp);
			errors++;
		end
	endtask

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic int latency();
		if (!randLat) begin
			return 0;
		end
		return int'(rand32() % 32'd4);
	endfunction

	// instruction encoders
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] encU(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	// lui + addi, upper part rounded for the signed low half
	task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] hi;
		hi = (value + 32'h800) >> 12;
		prog.push_back(encU(OP_LUI, rd, hi[19:0]));
		prog.push_back(encI(OP_IMM, 3'd0, rd, rd, value[11:0]));
	endtask

	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// one architectural step of the reference machine
	function automatic retire_t step();
		retire_t     r;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] next;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [2:0]  f3;
		logic        taken;
		int          sh;
		ins  = refMem[refPc[12:2]];
		f3   = ins[14:12];
		a    = refRegs[ins[19:15]];
		b    = refRegs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		next = refPc + 32'd4;
		res  = 32'd0;
		r    = '0;
		r.valid = 1'b1;
		r.pc    = refPc;
		r.rd    = ins[11:7];
		case (ins[6:0])
			OP_LUI: begin
				res = {ins[31:12], 12'b0};
				r.regWrite = 1'b1;
			end
			OP_AUIPC: begin
				res = refPc + {ins[31:12], 12'b0};
				r.regWrite = 1'b1;
			end
			OP_JAL: begin
				res  = refPc + 32'd4;
				next = (refPc + immJ) & ~32'd1;
				r.regWrite = 1'b1;
			end
			OP_JALR: begin
				res  = refPc + 32'd4;
				next = (a + immI) & ~32'd1;
				r.regWrite = 1'b1;
			end
			OP_BRANCH: begin
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					3'd5: taken = ($signed(a) >= $signed(b));
					3'd6: taken = (a < b);
					3'd7: taken = (a >= b);
					default: taken = 1'b0;
				endcase
				if (taken) begin
					next = refPc + immB;
				end
			end
			OP_LOAD: begin
				addr = a + immI;
				word = refMem[addr[12:2]] >> (8 * int'(addr[1:0]));
				case (f3)
					3'd0: res = {{24{word[7]}}, word[7:0]};
					3'd1: res = {{16{word[15]}}, word[15:0]};
					3'd4: res = {24'b0, word[7:0]};
					3'd5: res = {16'b0, word[15:0]};
					default: res = word;
				endcase
				r.regWrite = 1'b1;
			end
			OP_STORE: begin
				addr = a + immS;
				sh   = 8 * int'(addr[1:0]);
				case (f3)
					3'd0: refMem[addr[12:2]][sh +: 8] = b[7:0];
					3'd1: refMem[addr[12:2]][sh +: 16] = b[15:0];
					default: refMem[addr[12:2]] = b;
				endcase
			end
			OP_IMM: begin
				res = aluRef(f3, (f3 == 3'd5) & ins[30], a, immI);
				r.regWrite = 1'b1;
			end
			OP_REG: begin
				res = aluRef(f3, ins[30], a, b);
				r.regWrite = 1'b1;
			end
			default: begin
			end
		endcase
		if (r.regWrite && ins[11:7] != 5'd0) begin
			refRegs[ins[11:7]] = res;
		end
		r.wdata = res;
		refPc   = next;
		return r;
	endfunction

	// instruction port, ready after a random wait
	always @(posedge clk_mem) begin
		#1;
		if (rst) begin
			imemReady = 1'b0;
			iBusy     = 1'b0;
		end else if (imemReady) begin
			imemReady = 1'b0;
		end else if (imemRead) begin
			if (!iBusy) begin
				iBusy  = 1'b1;
				iDelay = latency();
			end
			if (iDelay == 0) begin
				iBusy     = 1'b0;
				imemData  = mem[imemAddr[12:2]];
				imemReady = 1'b1;
			end else begin
				iDelay--;
			end
		end
	end

	// data port
	always @(posedge clk_mem) begin
		#1;
		if (rst) begin
			dmemReady = 1'b0;
			dBusy     = 1'b0;
		end else if (dmemReady) begin
			dmemReady = 1'b0;
		end else if (dmemReq.read || dmemReq.write) begin
			if (!dBusy) begin
				dBusy  = 1'b1;
				dDelay = latency();
			end
			if (dDelay == 0) begin
				dBusy     = 1'b0;
				dmemRdata = mem[dmemReq.addr[12:2]];
				dmemReady = 1'b1;
				if (dmemReq.write) begin
					if (dmemReq.read || dmemReq.byteEn == 4'b0 || dmemReq.addr >= 32'h2000) begin
						$display("memory model: malformed write request to %08h", dmemReq.addr);
						errors++;
					end
					for (int b = 0; b < 4; b++) begin
						if (dmemReq.byteEn[b]) begin
							mem[dmemReq.addr[12:2]][8 * b +: 8] = dmemReq.wdata[8 * b +: 8];
						end
					end
				end
			end else begin
				dDelay--;
			end
		end
	end

	always @(posedge clk_mem) begin
		rstQ <= rst;
	end

	// compare every retire against the reference
	always @(negedge clk_mem) begin : compareRetire
		retire_t exp;
		if (rstQ && (imemRead || dmemReq.read || dmemReq.write || retire.valid)) begin
			$display("strobe or retire pulse seen while reset is held");
			errors++;
		end
		if (!rst) begin
			if (imemRead && imemReady) begin
				fetchCount++;
			end
			if (retire.valid) begin
				exp = step();
				retireCount++;
				check("retire.pc", retire.pc, exp.pc);
				check("retire.rd", 32'(retire.rd), 32'(exp.rd));
				check("retire.regWrite", 32'(retire.regWrite), 32'(exp.regWrite));
				if (exp.regWrite) begin
					check("retire.wdata", retire.wdata, exp.wdata);
				end
			end
		end
	end

	task automatic loadMemories();
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = (32'(i) * 32'h0100_0193) ^ 32'hc3a5_5a3c;
		end
		foreach (prog[k]) begin
			mem[int'(RESET_PC[12:2]) + k] = prog[k];
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			refMem[i] = mem[i];
		end
		for (int r = 0; r < 32; r++) begin
			refRegs[r] = 32'd0;
		end
		refPc       = RESET_PC;
		retireCount = 0;
		fetchCount  = 0;
	endtask

	task automatic runProgram(input string name);
		int          cycles;
		int          errStart;
		logic [31:0] endAddr;
		errStart = errors;
		endAddr  = RESET_PC + 32'(4 * prog.size());
		loadMemories();
		@(posedge clk_mem);
		#1;
		rst = 1'b1;
		repeat (3) @(posedge clk_mem);
		#1;
		rst = 1'b0;
		cycles = 0;
		while (!imemRead && cycles < TIMEOUT) begin
			@(posedge clk_mem);
			#1;
			cycles++;
		end
		if (!imemRead) begin
			$display("timeout: program %s never requested its first instruction", name);
			errors++;
		end else begin
			check("imemAddr", imemAddr, RESET_PC);
		end
		cycles = 0;
		while (refPc != endAddr && cycles < TIMEOUT) begin
			@(posedge clk_mem);
			#1;
			cycles++;
		end
		rst = 1'b1;
		if (refPc != endAddr) begin
			$display("timeout: program %s did not reach its last instruction", name);
			errors++;
		end else begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				check("mem", mem[i], refMem[i]);
			end
			check("fetchCount", 32'(fetchCount), 32'(retireCount));
		end
		testsRun++;
		if (errors != errStart) begin
			testsFailed++;
			$display("test %s failed, %0d retired", name, retireCount);
		end else begin
			$display("test %s ok, %0d retired", name, retireCount);
		end
	endtask

	task automatic genAlu();
		logic [31:0] rnd;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [4:0]  rs1;
		for (int r = 1; r <= 8; r++) begin
			loadConst(5'(r), rand32());
		end
		for (int k = 0; k < 40; k++) begin
			rnd = rand32();
			f3  = rnd[2:0];
			imm = rnd[27:16];
			// x0 as a source shows that writes to it were dropped
			rs1 = 5'((rnd[7:5] == 3'd7) ? 0 : 1 + rnd[7:5]);
			if (rnd[3]) begin
				prog.push_back(encR((rnd[4] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
					f3, 5'(rnd[15:8] % 8'd9), rs1, 5'(1 + rnd[30:28])));
			end else begin
				if (f3 == 3'd1 || f3 == 3'd5) begin
					imm = {1'b0, (f3 == 3'd5) && rnd[4], 5'b0, rnd[20:16]};
				end
				prog.push_back(encI(OP_IMM, f3, 5'(rnd[15:8] % 8'd9), rs1, imm));
			end
		end
	endtask

	task automatic genMem();
		loadConst(5'd10, DATA_BASE);
		loadConst(5'd11, rand32());
		loadConst(5'd12, rand32());
		prog.push_back(encS(3'd2, 5'd10, 5'd11, 12'd0));
		prog.push_back(encS(3'd1, 5'd10, 5'd12, 12'd4));
		prog.push_back(encS(3'd1, 5'd10, 5'd11, 12'd6));
		for (int k = 0; k < 4; k++) begin
			prog.push_back(encS(3'd0, 5'd10, (k % 2 == 0) ? 5'd11 : 5'd12, 12'(8 + k)));
		end
		for (int k = 0; k < 12; k++) begin
			prog.push_back(encI(OP_LOAD, 3'd0, 5'd14, 5'd10, 12'(k)));
			prog.push_back(encI(OP_LOAD, 3'd4, 5'd15, 5'd10, 12'(k)));
		end
		for (int k = 0; k < 12; k += 2) begin
			prog.push_back(encI(OP_LOAD, 3'd1, 5'd14, 5'd10, 12'(k)));
			prog.push_back(encI(OP_LOAD, 3'd5, 5'd15, 5'd10, 12'(k)));
		end
		for (int k = 0; k < 12; k += 4) begin
			prog.push_back(encI(OP_LOAD, 3'd2, 5'd16, 5'd10, 12'(k)));
		end
	endtask

	task automatic genBranch();
		logic [2:0]  conds [6];
		logic [31:0] target;
		conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		loadConst(5'd1, 32'hffff_fffb);
		loadConst(5'd2, 32'd3);
		loadConst(5'd3, 32'd7);
		loadConst(5'd4, 32'd7);
		foreach (conds[c]) begin
			prog.push_back(encB(conds[c], 5'd1, 5'd2, 13'd8));
			prog.push_back(encI(OP_IMM, 3'd0, 5'd5, 5'd5, 12'd1));
			prog.push_back(encB(conds[c], 5'd2, 5'd1, 13'd8));
			prog.push_back(encI(OP_IMM, 3'd0, 5'd5, 5'd5, 12'd2));
			prog.push_back(encB(conds[c], 5'd3, 5'd4, 13'd8));
			prog.push_back(encI(OP_IMM, 3'd0, 5'd5, 5'd5, 12'd4));
		end
		prog.push_back(encJ(5'd6, 21'd8));
		prog.push_back(encI(OP_IMM, 3'd0, 5'd5, 5'd5, 12'd100));
		// rs1 + 1 is odd, the core clears bit 0
		target = RESET_PC + 32'(4 * (prog.size() + 4));
		loadConst(5'd7, target);
		prog.push_back(encI(OP_JALR, 3'd0, 5'd8, 5'd7, 12'd1));
		prog.push_back(encI(OP_IMM, 3'd0, 5'd5, 5'd5, 12'd100));
		prog.push_back(encR(7'h00, 3'd0, 5'd9, 5'd5, 5'd8));
	endtask

	task automatic genUpper();
		logic [31:0] rnd;
		rnd = rand32();
		prog.push_back(encU(OP_LUI, 5'd20, rnd[19:0]));
		prog.push_back(encU(OP_AUIPC, 5'd21, rnd[31:12]));
		prog.push_back(32'h0000_0b7f);
		prog.push_back(32'h0ff0_000f);
		prog.push_back(encI(OP_IMM, 3'd0, 5'd23, 5'd20, 12'd1));
	endtask

	initial begin
		rst       = 1'b1;
		imemData  = 32'd0;
		imemReady = 1'b0;
		dmemRdata = 32'd0;
		dmemReady = 1'b0;

		prog.delete();
		prog.push_back(encI(OP_IMM, 3'd0, 5'd1, 5'd0, 12'd5));
		prog.push_back(encI(OP_IMM, 3'd0, 5'd2, 5'd1, 12'd7));
		runProgram("resetFetch");
		prog.delete();
		genAlu();
		runProgram("aluRandom");
		prog.delete();
		genMem();
		runProgram("storeLoad");
		prog.delete();
		genBranch();
		runProgram("branchJump");
		prog.delete();
		genUpper();
		runProgram("upperUnsupported");

		// same mix with the memory stalling at random
		randLat = 1'b1;
		prog.delete();
		genAlu();
		genMem();
		genBranch();
		genUpper();
		runProgram("mixedRandomLatency");

		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
source/rvCorePkg.sv
source/instrDecode.sv
source/regFile.sv
source/execUnit.sv
source/resultSelect.sv
source/coreSequencer.sv
source/rvCore.sv
sim/rvCore_props.sv
sim/rvCoreTb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rvCoreTb -f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/VrvCoreTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1
